// ==== hw/phy_tx_settings.svh ====
/*
 * Frame geometry, pipeline depth, line constants and CRC polynomials of the TX framer.
 * Include wherever these values are needed.
 */
`ifndef PHY_TX_SETTINGS_SVH
`define PHY_TX_SETTINGS_SVH

// A frame is one FAW followed by this many blocks
`define PHY_BLOCKS_PER_FRAME 4
// Data slots in a block, the CRC word follows them
`define PHY_SLOTS_PER_BLOCK 6

// Cycles from input handshake to the line output
`define PHY_PIPE_DEPTH 3

// Fixed line words
`define PHY_IDLE_WORD 64'h0000_0000_0000_0000
`define PHY_FAW_WORD 64'h7F7F_8080_7F7F_8080

// CRC-16 runs over slot pairs, CRC-8 over the slot valid bits
`define PHY_CRC16_POLY 16'h1021
`define PHY_CRC16_INIT 16'hFFFF
`define PHY_CRC8_POLY 8'h07
`define PHY_CRC8_INIT 8'h00

`endif

// ==== hw/phy_frame_pkg.sv ====
/*
 * Line word formats of the TX framer: slot items, VD packets and CRC sets.
 * Imported by the framer modules that build or check line words.
 */
package phy_frame_pkg;

   `include "phy_tx_settings.svh"

   // Kind of word carried by a slot in the pipeline
   typedef enum logic [1:0] {
      SLOT_DATA,
      SLOT_FAW,
      SLOT_CRC
   } slot_kind_e;

   // Unfilled data slots carry the IDLE word with valid low
   typedef struct packed {
      slot_kind_e  kind;
      logic [63:0] word;
      logic        valid;
   } tx_slot_t;

   // Tag value that marks a VD packet
   localparam logic [1:0] VD_TAG = 2'd2;

   typedef struct packed {
      logic [1:0]                      tag;
      logic [`PHY_SLOTS_PER_BLOCK-1:0] valids;
      logic [15:0]                     crc45;
      logic [15:0]                     crc23;
      logic [15:0]                     crc01;
      logic [7:0]                      crcvw;
   } vd_pkt_t;

   // One finished set of block CRCs
   typedef struct packed {
      logic [15:0] crc45;
      logic [15:0] crc23;
      logic [15:0] crc01;
      logic [7:0]  crcvw;
   } crc_set_t;

   function automatic logic is_faw(input logic [63:0] word);
      return word == `PHY_FAW_WORD;
   endfunction

endpackage

// ==== hw/phy_link_pkg.sv ====
/*
 * Link control types shared by the link FSM, the frame timer and the packet generator.
 */
package phy_link_pkg;

   // Transmit mode chosen by the link FSM
   typedef enum logic [1:0] {
      TX_OFF,
      TX_IDLE,
      TX_ACTIVE
   } tx_mode_e;

   // Boundary strobes for the slot presented this cycle.
   // At most one of them is set in any cycle
   typedef struct packed {
      logic faw;
      logic crc;
   } tx_bnd_t;

endpackage

// ==== hw/tx_link_fsm.sv ====
/*
 * Link FSM of the TX framer. Selects OFF, IDLE or ACTIVE from the local enable
 * and the partner readiness, with a registered mode output.
 */
`timescale 1ns/1ns

module tx_link_fsm (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  enable_i,
   input  logic                  rx_rdy_i,
   output phy_link_pkg::tx_mode_e mode_o
);

   import phy_link_pkg::*;

   tx_mode_e state_q;
   tx_mode_e state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         TX_OFF: begin
            state_d = TX_IDLE;
         end
         TX_IDLE: begin
            if (rx_rdy_i) begin
               state_d = TX_ACTIVE;
            end
         end
         TX_ACTIVE: begin
            if (!rx_rdy_i) begin
               state_d = TX_IDLE;
            end
         end
         default: begin
            state_d = TX_OFF;
         end
      endcase
      // Losing the enable wins over every other transition
      if (!enable_i) begin
         state_d = TX_OFF;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= TX_OFF;
      end else begin
         state_q <= state_d;
      end
   end

   assign mode_o = state_q;

endmodule

// ==== hw/tx_boundary_timer.sv ====
/*
 * Frame position counter. Raises the FAW strobe at position 0 and the CRC strobe
 * at the last word of each block, in every link mode.
 */
`timescale 1ns/1ns

module tx_boundary_timer (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   output phy_link_pkg::tx_bnd_t bnd_o
);

   import phy_link_pkg::*;

   `include "phy_tx_settings.svh"

   // A block is its data slots plus one CRC word
   localparam int BLOCK_WORDS = `PHY_SLOTS_PER_BLOCK + 1;
   localparam int FRAME_WORDS = 1 + `PHY_BLOCKS_PER_FRAME * BLOCK_WORDS;
   localparam int POS_W = $clog2(FRAME_WORDS);
   localparam int BLK_W = $clog2(BLOCK_WORDS + 1);

   logic [POS_W-1:0] pos_q;
   // Position inside the current block, 0 only on the FAW word
   logic [BLK_W-1:0] blk_pos_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pos_q     <= '0;
         blk_pos_q <= '0;
      end else begin
         if (pos_q == POS_W'(FRAME_WORDS - 1)) begin
            pos_q     <= '0;
            blk_pos_q <= '0;
         end else begin
            pos_q <= pos_q + 1'b1;
            if (blk_pos_q == BLK_W'(BLOCK_WORDS)) begin
               blk_pos_q <= BLK_W'(1);
            end else begin
               blk_pos_q <= blk_pos_q + 1'b1;
            end
         end
      end
   end

   always_comb begin
      bnd_o     = '0;
      bnd_o.faw = (pos_q == '0);
      bnd_o.crc = (blk_pos_q == BLK_W'(BLOCK_WORDS));
   end

endmodule

// ==== hw/tx_crc_accum.sv ====
/*
 * Block CRC accumulator. Runs one CRC-16 per slot pair over the data words and a
 * CRC-8 over the six valid bits, then presents the set for the block's CRC word.
 */
`timescale 1ns/1ns

module tx_crc_accum (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  phy_frame_pkg::tx_slot_t slot_i,
   input  logic                   slot_valid_i,
   output phy_frame_pkg::crc_set_t crc_o,
   output logic                   crc_valid_o
);

   import phy_frame_pkg::*;

   `include "phy_tx_settings.svh"

   localparam int SLOTS = `PHY_SLOTS_PER_BLOCK;
   localparam int NUM_PAIRS = SLOTS / 2;
   localparam int CNT_W = $clog2(SLOTS);
   localparam int PAIR_W = $clog2(NUM_PAIRS);

   // Feeds one 64-bit word through the CRC-16 starting at the MSB
   function automatic logic [15:0] crc16_word(input logic [15:0] crc_in, input logic [63:0] data);
      logic [15:0] crc;
      logic        fb;
      crc = crc_in;
      for (int i = 63; i >= 0; i--) begin
         fb  = crc[15] ^ data[i];
         crc = {crc[14:0], 1'b0};
         if (fb) begin
            crc = crc ^ `PHY_CRC16_POLY;
         end
      end
      return crc;
   endfunction

   // Feeds the valid bits through the CRC-8 starting at the highest slot
   function automatic logic [7:0] crc8_bits(input logic [SLOTS-1:0] bits);
      logic [7:0] crc;
      logic       fb;
      crc = `PHY_CRC8_INIT;
      for (int i = SLOTS - 1; i >= 0; i--) begin
         fb  = crc[7] ^ bits[i];
         crc = {crc[6:0], 1'b0};
         if (fb) begin
            crc = crc ^ `PHY_CRC8_POLY;
         end
      end
      return crc;
   endfunction

   logic [CNT_W-1:0]  cnt_q;
   logic [15:0]       pair_q [NUM_PAIRS];
   logic [1:0]        hold_q;
   logic [SLOTS-1:0]  vbits_q;
   crc_set_t          crc_q;

   logic              data_slot;
   logic              last_slot;
   logic [PAIR_W-1:0] pair_idx;
   logic [15:0]       pair_next;
   logic [SLOTS-1:0]  vbits_next;

   // Only data slots count and the CRC slot passes through untouched
   assign data_slot  = slot_valid_i && (slot_i.kind == SLOT_DATA);
   assign last_slot  = data_slot && (cnt_q == CNT_W'(SLOTS - 1));
   assign pair_idx   = PAIR_W'(cnt_q >> 1);
   assign pair_next  = crc16_word(pair_q[pair_idx], slot_i.word);
   assign vbits_next = {slot_i.valid, vbits_q[SLOTS-1:1]};

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q  <= '0;
         hold_q <= '0;
         for (int p = 0; p < NUM_PAIRS; p++) begin
            pair_q[p] <= `PHY_CRC16_INIT;
         end
      end else begin
         // Result stays valid until the CRC word has left stage 2
         hold_q <= last_slot ? 2'b11 : {1'b0, hold_q[1]};
         if (last_slot) begin
            cnt_q <= '0;
            for (int p = 0; p < NUM_PAIRS; p++) begin
               pair_q[p] <= `PHY_CRC16_INIT;
            end
         end else if (data_slot) begin
            cnt_q            <= cnt_q + 1'b1;
            pair_q[pair_idx] <= pair_next;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (data_slot) begin
         vbits_q <= vbits_next;
      end
      if (last_slot) begin
         crc_q.crc01 <= pair_q[0];
         crc_q.crc23 <= pair_q[1];
         crc_q.crc45 <= pair_next;
         crc_q.crcvw <= crc8_bits(vbits_next);
      end
   end

   assign crc_o       = crc_q;
   assign crc_valid_o = hold_q[0];

endmodule

// ==== hw/tx_packet_gen.sv ====
/*
 * Three-stage TX pipeline. Accepts user words into data slots and turns each slot
 * into the FAW word, a VD packet, the user word or the IDLE word on the line.
 */
`timescale 1ns/1ns

module tx_packet_gen (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  phy_link_pkg::tx_mode_e  mode_i,
   input  phy_link_pkg::tx_bnd_t   bnd_i,
   input  logic [63:0]            s_tdata_i,
   input  logic                   s_tvalid_i,
   output logic                   s_tready_o,
   input  phy_frame_pkg::crc_set_t crc_i,
   input  logic                   crc_valid_i,
   output phy_frame_pkg::tx_slot_t slot_o,
   output logic                   slot_valid_o,
   output logic [63:0]            m_tdata_o
);

   import phy_frame_pkg::*;
   import phy_link_pkg::*;

   `include "phy_tx_settings.svh"

   localparam int SLOTS = `PHY_SLOTS_PER_BLOCK;
   localparam int FILL_W = `PHY_PIPE_DEPTH - 1;

   // One bit per slot stage that fills with ones after reset
   logic [FILL_W-1:0] fill_q;

   logic             handshake;
   tx_slot_t         s1_slot_d;
   tx_slot_t         s1_slot_q;
   tx_mode_e         s1_mode_q;
   tx_slot_t         s2_slot_q;
   tx_mode_e         s2_mode_q;
   logic [SLOTS-1:0] hist_q;
   vd_pkt_t          vd;
   logic [63:0]      line_d;
   logic [63:0]      line_q;

   // No transfers on boundaries or outside ACTIVE
   assign s_tready_o = (mode_i == TX_ACTIVE) && !bnd_i.faw && !bnd_i.crc;
   assign handshake  = s_tvalid_i && s_tready_o;

   always_comb begin
      if (bnd_i.faw) begin
         s1_slot_d.kind = SLOT_FAW;
      end else if (bnd_i.crc) begin
         s1_slot_d.kind = SLOT_CRC;
      end else begin
         s1_slot_d.kind = SLOT_DATA;
      end
      s1_slot_d.word  = handshake ? s_tdata_i : `PHY_IDLE_WORD;
      s1_slot_d.valid = handshake;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fill_q <= '0;
      end else begin
         fill_q <= (fill_q << 1) | FILL_W'(1);
      end
   end

   // Stage 1 and stage 2 slot registers carry the mode of each slot along
   always_ff @(posedge clk_i) begin
      s1_slot_q <= s1_slot_d;
      s1_mode_q <= mode_i;
      s2_slot_q <= s1_slot_q;
      s2_mode_q <= s1_mode_q;
      // Oldest slot of the block ends up in bit 0
      if (fill_q[0] && (s1_slot_q.kind == SLOT_DATA)) begin
         hist_q <= {s1_slot_q.valid, hist_q[SLOTS-1:1]};
      end
   end

   always_comb begin
      vd        = '0;
      vd.tag    = VD_TAG;
      vd.valids = (s2_mode_q == TX_ACTIVE) ? hist_q : '0;
      vd.crc45  = crc_i.crc45;
      vd.crc23  = crc_i.crc23;
      vd.crc01  = crc_i.crc01;
      vd.crcvw  = crc_i.crcvw;
   end

   always_comb begin
      line_d = `PHY_IDLE_WORD;
      if (fill_q[FILL_W-1] && (s2_mode_q != TX_OFF)) begin
         case (s2_slot_q.kind)
            SLOT_FAW: begin
               line_d = `PHY_FAW_WORD;
            end
            SLOT_CRC: begin
               // Without a finished CRC set the slot stays idle
               if (crc_valid_i) begin
                  line_d = vd;
               end
            end
            default: begin
               line_d = s2_slot_q.word;
            end
         endcase
      end
   end

   // Stage 3 drives the line
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         line_q <= `PHY_IDLE_WORD;
      end else begin
         line_q <= line_d;
      end
   end

   assign slot_o       = s1_slot_q;
   assign slot_valid_o = fill_q[0];
   assign m_tdata_o    = line_q;

endmodule

// ==== hw/phy_tx_top.sv ====
/*
 * Top level of the PHY TX framer. Connects the link FSM, the frame timer, the CRC
 * accumulator and the packet generator between the user stream and the line.
 */
`timescale 1ns/1ns

module phy_tx_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  enable_i,
   input  logic                  rx_rdy_i,
   input  logic [63:0]           s_tdata_i,
   input  logic                  s_tvalid_i,
   output logic                  s_tready_o,
   output logic [63:0]           m_tdata_o,
   output phy_link_pkg::tx_mode_e tx_mode_o
);

   import phy_frame_pkg::*;
   import phy_link_pkg::*;

   tx_mode_e mode;
   tx_bnd_t  bnd;
   tx_slot_t slot;
   logic     slot_valid;
   crc_set_t crc_set;
   logic     crc_valid;

   tx_link_fsm i_link_fsm (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .enable_i (enable_i),
      .rx_rdy_i (rx_rdy_i),
      .mode_o   (mode)
   );

   tx_boundary_timer i_boundary_timer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bnd_o   (bnd)
   );

   tx_crc_accum i_crc_accum (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .slot_i       (slot),
      .slot_valid_i (slot_valid),
      .crc_o        (crc_set),
      .crc_valid_o  (crc_valid)
   );

   tx_packet_gen i_packet_gen (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .mode_i       (mode),
      .bnd_i        (bnd),
      .s_tdata_i    (s_tdata_i),
      .s_tvalid_i   (s_tvalid_i),
      .s_tready_o   (s_tready_o),
      .crc_i        (crc_set),
      .crc_valid_i  (crc_valid),
      .slot_o       (slot),
      .slot_valid_o (slot_valid),
      .m_tdata_o    (m_tdata_o)
   );

   assign tx_mode_o = mode;

endmodule

// ==== tests/phy_tx_properties.sv ====
/*
 * Concurrent assertions on the PHY TX framer, bound into phy_tx_top.
 * Covers the ready rule, boundary strobes, pipeline latency and VD packet fields.
 */
`timescale 1ns/1ns

module phy_tx_properties (
   input logic                   clk_i,
   input logic                   rst_n_i,
   input logic                   enable_i,
   input logic                   rx_rdy_i,
   input phy_link_pkg::tx_mode_e mode_i,
   input phy_link_pkg::tx_bnd_t  bnd_i,
   input logic [63:0]            s_tdata_i,
   input logic                   s_tvalid_i,
   input logic                   s_tready_o,
   input logic                   crc_valid_i,
   input logic [63:0]            m_tdata_o
);

   import phy_frame_pkg::*;
   import phy_link_pkg::*;

   `include "phy_tx_settings.svh"

   localparam int DEPTH = `PHY_PIPE_DEPTH;

   // Number of failed assertions
   int fail_cnt = 0;

   // Ready needs ACTIVE and ACTIVE needs enable and partner readiness one cycle earlier
   a_ready_rule: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_tready_o |-> $past(enable_i && rx_rdy_i))
      else begin
         fail_cnt++;
         $error("s_tready_o high without enable and partner readiness one cycle before");
      end

   a_bnd_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(bnd_i.faw && bnd_i.crc))
      else begin
         fail_cnt++;
         $error("FAW and CRC strobes set in the same cycle");
      end

   a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_tvalid_i && s_tready_o |-> ##DEPTH m_tdata_o == $past(s_tdata_i, DEPTH))
      else begin
         fail_cnt++;
         $error("accepted word did not reach the line after the pipeline delay");
      end

   // The CRC set must be finished when the CRC slot sits in stage 2
   a_crc_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bnd_i.crc |-> ##2 crc_valid_i)
      else begin
         fail_cnt++;
         $error("CRC set not valid for the CRC slot");
      end

   a_faw_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(bnd_i.faw, DEPTH) && $past(mode_i, DEPTH) != TX_OFF |-> is_faw(m_tdata_o))
      else begin
         fail_cnt++;
         $error("FAW slot did not produce the FAW word");
      end

   a_idle_valids: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(bnd_i.crc, DEPTH) && $past(mode_i, DEPTH) == TX_IDLE
      |-> m_tdata_o[63:56] == {VD_TAG, 6'd0})
      else begin
         fail_cnt++;
         $error("VD packet in IDLE mode has a wrong tag or valid bits");
      end

endmodule

bind phy_tx_top phy_tx_properties i_props (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .enable_i    (enable_i),
   .rx_rdy_i    (rx_rdy_i),
   .mode_i      (mode),
   .bnd_i       (bnd),
   .s_tdata_i   (s_tdata_i),
   .s_tvalid_i  (s_tvalid_i),
   .s_tready_o  (s_tready_o),
   .crc_valid_i (crc_valid),
   .m_tdata_o   (m_tdata_o)
);

// ==== tests/phy_tx_checker.sv ====
/*
 * Reference model of the PHY TX framer. Watches the top-level ports, predicts each
 * line word, the ready output and the mode, and reports every mismatch.
 */
`timescale 1ns/1ns

module phy_tx_checker (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   enable_i,
   input  logic                   rx_rdy_i,
   input  logic [63:0]            s_tdata_i,
   input  logic                   s_tvalid_i,
   input  logic                   s_tready_o,
   input  logic [63:0]            m_tdata_o,
   input  phy_link_pkg::tx_mode_e tx_mode_o,
   output int                     err_cnt_o,
   output int                     acc_cnt_o,
   output int                     vd_cnt_o
);

   import phy_link_pkg::*;

   `include "phy_tx_settings.svh"

   localparam int SLOTS = `PHY_SLOTS_PER_BLOCK;
   localparam int BLOCK_WORDS = SLOTS + 1;
   localparam int FRAME_WORDS = 1 + `PHY_BLOCKS_PER_FRAME * BLOCK_WORDS;

   // Predicted line words, oldest first
   logic [63:0]      pred_q[$];
   tx_mode_e         mode_m;
   int               pos;
   int               nslot;
   logic [15:0]      crc16_m [SLOTS/2];
   logic [SLOTS-1:0] vbits_m;
   logic [63:0]      word;
   logic             rdy_m;
   logic             hs;

   function automatic logic [15:0] crc16_update(input logic [15:0] c, input logic [63:0] w);
      logic [15:0] r;
      r = c;
      for (int b = 63; b >= 0; b--) begin
         r = (r[15] ^ w[b]) ? ((r << 1) ^ `PHY_CRC16_POLY) : (r << 1);
      end
      return r;
   endfunction

   // Slot 5 goes in first
   function automatic logic [7:0] crc8_valids(input logic [SLOTS-1:0] v);
      logic [7:0] r;
      r = `PHY_CRC8_INIT;
      for (int b = SLOTS - 1; b >= 0; b--) begin
         r = (r[7] ^ v[b]) ? ((r << 1) ^ `PHY_CRC8_POLY) : (r << 1);
      end
      return r;
   endfunction

   task automatic clear_block();
      nslot   = 0;
      vbits_m = '0;
      for (int p = 0; p < SLOTS / 2; p++) begin
         crc16_m[p] = `PHY_CRC16_INIT;
      end
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      err_cnt_o++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
   endtask

   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pred_q.delete();
         repeat (`PHY_PIPE_DEPTH) pred_q.push_back(`PHY_IDLE_WORD);
         mode_m    = TX_OFF;
         pos       = 0;
         err_cnt_o = 0;
         acc_cnt_o = 0;
         vd_cnt_o  = 0;
         clear_block();
      end else begin
         word = pred_q.pop_front();
         if (m_tdata_o !== word) begin
            report_mismatch("m_tdata_o", word, m_tdata_o);
         end
         if (tx_mode_o !== mode_m) begin
            report_mismatch("tx_mode_o", 64'(mode_m), 64'(tx_mode_o));
         end
         // Position 0 and every block end are boundaries
         rdy_m = (mode_m == TX_ACTIVE) && (pos % BLOCK_WORDS != 0);
         if (s_tready_o !== rdy_m) begin
            report_mismatch("s_tready_o", 64'(rdy_m), 64'(s_tready_o));
         end
         hs = s_tvalid_i && rdy_m;
         if (pos == 0) begin
            word = `PHY_FAW_WORD;
         end else if (pos % BLOCK_WORDS == 0) begin
            word = {2'd2, (mode_m == TX_ACTIVE) ? vbits_m : 6'd0,
                    crc16_m[2], crc16_m[1], crc16_m[0], crc8_valids(vbits_m)};
            if (mode_m == TX_ACTIVE && vbits_m != '0) begin
               vd_cnt_o++;
            end
            clear_block();
         end else begin
            word = hs ? s_tdata_i : `PHY_IDLE_WORD;
            crc16_m[nslot / 2] = crc16_update(crc16_m[nslot / 2], word);
            vbits_m[nslot] = hs;
            nslot++;
            acc_cnt_o += hs;
         end
         pred_q.push_back((mode_m == TX_OFF) ? `PHY_IDLE_WORD : word);
         if (!enable_i) begin
            mode_m = TX_OFF;
         end else if (mode_m == TX_OFF) begin
            mode_m = TX_IDLE;
         end else begin
            mode_m = rx_rdy_i ? TX_ACTIVE : TX_IDLE;
         end
         pos = (pos + 1) % FRAME_WORDS;
      end
   end

endmodule

// ==== tests/phy_tx_tb.sv ====
/*
 * Testbench of the PHY TX framer. Steps the link through OFF, IDLE and ACTIVE with
 * seeded random user traffic while the checker predicts every line word.
 */
`timescale 1ns/1ns

module phy_tx_tb;

   import phy_link_pkg::*;

   `include "phy_tx_settings.svh"

   localparam int FRAME_WORDS = 1 + `PHY_BLOCKS_PER_FRAME * (`PHY_SLOTS_PER_BLOCK + 1);
   localparam int MODE_TIMEOUT = 8;

   logic        clk_i;
   logic        rst_n_i;
   logic        enable_i;
   logic        rx_rdy_i;
   logic [63:0] s_tdata_i;
   logic        s_tvalid_i;
   logic        s_tready_o;
   logic [63:0] m_tdata_o;
   tx_mode_e    tx_mode_o;
   int          chk_errs;
   int          acc_cnt;
   int          vd_cnt;
   integer      seed;
   logic        hs_next;
   int          held_cnt;
   int          tb_errs;
   int          tests_run;
   int          tests_failed;
   int          errs_at_start;
   int          mark;

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   phy_tx_top i_dut (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .enable_i   (enable_i),
      .rx_rdy_i   (rx_rdy_i),
      .s_tdata_i  (s_tdata_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .m_tdata_o  (m_tdata_o),
      .tx_mode_o  (tx_mode_o)
   );

   phy_tx_checker i_chk (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .enable_i   (enable_i),
      .rx_rdy_i   (rx_rdy_i),
      .s_tdata_i  (s_tdata_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .m_tdata_o  (m_tdata_o),
      .tx_mode_o  (tx_mode_o),
      .err_cnt_o  (chk_errs),
      .acc_cnt_o  (acc_cnt),
      .vd_cnt_o   (vd_cnt)
   );

   function automatic int total_errors();
      return chk_errs + i_dut.i_props.fail_cnt + tb_errs;
   endfunction

   // One cycle of stimulus. A pending word stays on the bus until it is taken
   task automatic drive_step(input logic always_valid);
      @(negedge clk_i);
      if (!s_tvalid_i || hs_next) begin
         s_tvalid_i = always_valid || (($random(seed) & 1) != 0);
         s_tdata_i  = {$random(seed), $random(seed)};
      end
      hs_next = s_tvalid_i && s_tready_o;
      if (s_tvalid_i && !s_tready_o && tx_mode_o == TX_ACTIVE) begin
         held_cnt++;
      end
   endtask

   task automatic drive_cycles(input int n, input logic always_valid);
      repeat (n) drive_step(always_valid);
   endtask

   task automatic wait_mode(input tx_mode_e target, input logic always_valid);
      int n;
      n = 0;
      while (tx_mode_o != target && n < MODE_TIMEOUT) begin
         drive_step(always_valid);
         n++;
      end
      if (tx_mode_o != target) begin
         $display("Timeout: tx_mode_o did not reach %s within %0d cycles",
                  target.name(), MODE_TIMEOUT);
         tb_errs++;
      end
   endtask

   task automatic expect_activity(input logic seen, input string what);
      if (!seen) begin
         $display("Stimulus problem: %s", what);
         tb_errs++;
      end
   endtask

   task automatic end_test(input string name);
      int n;
      n = total_errors() - errs_at_start;
      tests_run++;
      if (n == 0) begin
         $display("Test %s: passed", name);
      end else begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", name, n);
      end
   endtask

   initial begin
      seed         = 26;
      rst_n_i      = 1'b0;
      enable_i     = 1'b0;
      rx_rdy_i     = 1'b0;
      s_tdata_i    = '0;
      s_tvalid_i   = 1'b0;
      hs_next      = 1'b0;
      held_cnt     = 0;
      tb_errs      = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      // Random valid in OFF must never meet a ready
      errs_at_start = total_errors();
      drive_cycles(2 * FRAME_WORDS, 1'b0);
      end_test("1 OFF mode");

      errs_at_start = total_errors();
      enable_i = 1'b1;
      wait_mode(TX_IDLE, 1'b0);
      drive_cycles(2 * FRAME_WORDS, 1'b0);
      end_test("2 IDLE mode");

      errs_at_start = total_errors();
      mark = acc_cnt;
      rx_rdy_i = 1'b1;
      wait_mode(TX_ACTIVE, 1'b0);
      drive_cycles(6 * FRAME_WORDS, 1'b0);
      expect_activity(acc_cnt > mark, "no user word was accepted in ACTIVE mode");
      end_test("3 ACTIVE data path");

      errs_at_start = total_errors();
      mark = vd_cnt;
      drive_cycles(4 * FRAME_WORDS, 1'b0);
      expect_activity(vd_cnt > mark, "no VD packet carried valid bits");
      end_test("4 VD packet contents");

      // With valid always high the words wait at every boundary
      errs_at_start = total_errors();
      mark = held_cnt;
      drive_cycles(2 * FRAME_WORDS, 1'b1);
      expect_activity(held_cnt > mark, "no word was held across a boundary");
      end_test("5 ready rule");

      errs_at_start = total_errors();
      rx_rdy_i = 1'b0;
      wait_mode(TX_IDLE, 1'b0);
      drive_cycles(FRAME_WORDS, 1'b0);
      enable_i = 1'b0;
      wait_mode(TX_OFF, 1'b0);
      drive_cycles(FRAME_WORDS + `PHY_PIPE_DEPTH, 1'b0);
      end_test("6 mode fall-back");

      $display("Summary: %0d tests, %0d failed, %0d errors, %0d words accepted",
               tests_run, tests_failed, total_errors(), acc_cnt);
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/phy_frame_pkg.sv
hw/phy_link_pkg.sv
hw/tx_link_fsm.sv
hw/tx_boundary_timer.sv
hw/tx_crc_accum.sv
hw/tx_packet_gen.sv
hw/phy_tx_top.sv
tests/phy_tx_properties.sv
tests/phy_tx_checker.sv
tests/phy_tx_tb.sv
